// File: qspi_pkg.sv
// shared types and constants for the quad-SPI memory controller
// holds the request, APB and configuration structs, the FSM state enum,
// the register map and the register reset values
package qspi_pkg;

	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} xfer_size_e;

	typedef enum logic [2:0] {
		st_idle,
		st_cmd,
		st_adr,
		st_wait,
		st_rdata,
		st_wdata,
		st_ce_turn
	} qspi_state_e;

	// one host transfer, chip select in addr[25:24]
	typedef struct packed {
		logic        is_write;
		xfer_size_e  size;
		logic [25:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [3:0] latency0;
		logic [3:0] latency1;
		logic [3:0] latency2;
		logic [9:0] sck_div;
		logic [7:0] rd_cmd;
		logic [7:0] wr_cmd;
	} qspi_cfg_t;

	typedef struct packed {
		logic fall;
		logic sample;
	} sck_evt_t;

	// register map
	localparam logic [7:0] reg_latency0 = 8'h00;
	localparam logic [7:0] reg_latency1 = 8'h04;
	localparam logic [7:0] reg_latency2 = 8'h08;
	localparam logic [7:0] reg_sck_div  = 8'h0C;
	localparam logic [7:0] reg_rd_cmd   = 8'h10;
	localparam logic [7:0] reg_wr_cmd   = 8'h14;

	localparam logic [3:0] latency_rst = 4'd7;
	localparam logic [9:0] sck_div_rst = 10'd3;
	localparam logic [7:0] rd_cmd_rst  = 8'hEB;
	localparam logic [7:0] wr_cmd_rst  = 8'h38;

	localparam int sync_stages = 3;
	localparam int cmd_bits    = 8;
	localparam int adr_nibbles = 6;
	localparam int num_ce      = 3;
	localparam int sck_div_min = 3;

	// index of the last data nibble for a transfer size
	function automatic logic [2:0] nibble_last(xfer_size_e size);
		case (size)
			size_byte: return 3'd1;
			size_half: return 3'd3;
			default:   return 3'd7;
		endcase
	endfunction

endpackage

// File: qspi_sck_gen.sv
`timescale 1ns/1ps
// free running SCK divider for the quad-SPI controller
// each SCK half period lasts sck_div+1 clocks, SCK idles high;
// also produces the fall strobe and the delayed read sample strobe
module qspi_sck_gen import qspi_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  qspi_cfg_t cfg,
	output logic      sck,
	output sck_evt_t  evt
);

	logic [9:0] div_eff;
	logic [9:0] cnt;
	logic half;
	logic sck_q;
	logic [sync_stages:0] sck_hist;

	// never run faster than the sampling path allows
	assign div_eff = (cfg.sck_div < 10'(sck_div_min)) ? 10'(sck_div_min) : cfg.sck_div;
	assign half = (cnt >= div_eff);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			sck_q <= 1'b1;
			sck_hist <= '1;
		end else begin
			cnt <= half ? 10'd0 : cnt + 10'd1;
			if (half)
				sck_q <= ~sck_q;
			sck_hist <= {sck_hist[sync_stages-1:0], sck_q};
		end
	end

	assign sck = sck_q;
	// sck goes low at the next edge
	assign evt.fall = half & sck_q;
	// rising edge seen through the same depth as the SIO synchronizer
	assign evt.sample = sck_hist[sync_stages-1] & ~sck_hist[sync_stages];

endmodule

// File: qspi_cfg_regs.sv
`timescale 1ns/1ps
// APB slave with the quad-SPI configuration registers
// zero wait states, writes land in the access phase, reads are
// combinational on paddr and unmapped offsets read as zero
module qspi_cfg_regs import qspi_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  apb_req_t    apb,
	output logic [31:0] prdata,
	output qspi_cfg_t   cfg
);

	qspi_cfg_t cfg_q;
	logic wr_en;

	assign wr_en = apb.psel & apb.penable & apb.pwrite;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q.latency0 <= latency_rst;
			cfg_q.latency1 <= latency_rst;
			cfg_q.latency2 <= latency_rst;
			cfg_q.sck_div <= sck_div_rst;
			cfg_q.rd_cmd <= rd_cmd_rst;
			cfg_q.wr_cmd <= wr_cmd_rst;
		end else if (wr_en) begin
			// each field keeps only its own low bits
			case (apb.paddr)
				reg_latency0: cfg_q.latency0 <= apb.pwdata[3:0];
				reg_latency1: cfg_q.latency1 <= apb.pwdata[3:0];
				reg_latency2: cfg_q.latency2 <= apb.pwdata[3:0];
				reg_sck_div:  cfg_q.sck_div <= apb.pwdata[9:0];
				reg_rd_cmd:   cfg_q.rd_cmd <= apb.pwdata[7:0];
				reg_wr_cmd:   cfg_q.wr_cmd <= apb.pwdata[7:0];
				default: ;
			endcase
		end
	end

	// read mux
	always_comb begin
		prdata = '0;
		case (apb.paddr)
			reg_latency0: prdata[3:0] = cfg_q.latency0;
			reg_latency1: prdata[3:0] = cfg_q.latency1;
			reg_latency2: prdata[3:0] = cfg_q.latency2;
			reg_sck_div:  prdata[9:0] = cfg_q.sck_div;
			reg_rd_cmd:   prdata[7:0] = cfg_q.rd_cmd;
			reg_wr_cmd:   prdata[7:0] = cfg_q.wr_cmd;
			default: ;
		endcase
	end

	assign cfg = cfg_q;

endmodule

// File: qspi_req_latch.sv
`timescale 1ns/1ps
// holds the host request for the length of one transfer
// a mem_start pulse is taken only while idle, busy drops on done
module qspi_req_latch import qspi_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     mem_start,
	input  mem_req_t mem_req_in,
	input  logic     done,
	output mem_req_t req,
	output logic     busy
);

	logic take;

	// pulses while a transfer is open are dropped
	assign take = mem_start & ~busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			busy <= 1'b0;
		else if (take)
			busy <= 1'b1;
		else if (done)
			busy <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take)
			req <= mem_req_in;
	end

endmodule

// File: qspi_sequencer.sv
`timescale 1ns/1ps
// transfer FSM of the quad-SPI controller
// steps through command, address, dummy and data phases on SCK fall
// strobes, drives the chip selects and the host completion pulses
module qspi_sequencer import qspi_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  qspi_cfg_t         cfg,
	input  sck_evt_t          evt,
	input  mem_req_t          req,
	input  logic              busy,
	output qspi_state_e       state,
	output logic [2:0]        beat,
	output logic              drive_en,
	output logic              capture,
	output logic [num_ce-1:0] ce_n,
	output logic              done,
	output logic              read_valid,
	output logic              write_finish
);

	qspi_state_e state_q;
	logic [3:0] cnt;
	logic [1:0] chip_q;
	logic rd_done;
	logic [3:0] lat;
	logic [3:0] data_last;
	logic last_sample;
	logic active;
	logic [num_ce-1:0] ce_dec;

	// dummy cycles of the selected chip
	always_comb begin
		case (chip_q)
			2'd0: lat = cfg.latency0;
			2'd1: lat = cfg.latency1;
			default: lat = cfg.latency2;
		endcase
	end

	assign data_last = {1'b0, nibble_last(req.size)};
	assign capture = (state_q == st_rdata) && evt.sample && !rd_done;
	assign last_sample = capture && (cnt == 4'd0);
	assign write_finish = (state_q == st_wdata) && evt.fall && (cnt == 4'd0);
	assign done = read_valid | write_finish;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= st_idle;
			cnt <= '0;
			chip_q <= '0;
			rd_done <= 1'b0;
		end else begin
			// read beats advance on sample strobes
			if (capture && cnt != 4'd0)
				cnt <= cnt - 4'd1;
			if (last_sample)
				rd_done <= 1'b1;
			if (evt.fall) begin
				case (state_q)
					st_idle: if (busy) begin
						state_q <= st_cmd;
						cnt <= 4'(cmd_bits - 1);
						chip_q <= req.addr[25:24];
					end
					st_cmd: if (cnt == 4'd0) begin
						state_q <= st_adr;
						cnt <= 4'(adr_nibbles - 1);
					end else begin
						cnt <= cnt - 4'd1;
					end
					st_adr: if (cnt != 4'd0) begin
						cnt <= cnt - 4'd1;
					end else if (req.is_write) begin
						state_q <= st_wdata;
						cnt <= data_last;
					end else if (lat == 4'd0) begin
						state_q <= st_rdata;
						cnt <= data_last;
					end else begin
						state_q <= st_wait;
						cnt <= lat;
					end
					// counts lat down to 1 so exactly lat cycles pass
					st_wait: if (cnt == 4'd1) begin
						state_q <= st_rdata;
						cnt <= data_last;
					end else begin
						cnt <= cnt - 4'd1;
					end
					st_rdata: if (rd_done || last_sample) begin
						state_q <= st_ce_turn;
						rd_done <= 1'b0;
					end
					st_wdata: if (cnt == 4'd0)
						state_q <= st_ce_turn;
					else
						cnt <= cnt - 4'd1;
					default: state_q <= st_idle;
				endcase
			end
		end
	end

	assign active = state_q inside {st_cmd, st_adr, st_wait, st_rdata, st_wdata};

	always_comb begin
		for (int i = 0; i < num_ce; i++)
			ce_dec[i] = !(active && (chip_q == 2'(i)));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ce_n <= '1;
			read_valid <= 1'b0;
		end else begin
			ce_n <= ce_dec;
			read_valid <= last_sample;
		end
	end

	assign state = state_q;
	assign beat = cnt[2:0];
	assign drive_en = (state_q == st_cmd) || (state_q == st_adr) || (state_q == st_wdata);

endmodule

// File: qspi_io_shifter.sv
`timescale 1ns/1ps
// SIO datapath of the quad-SPI controller
// picks and registers the outgoing nibble, synchronizes the SIO inputs
// and assembles read data in host byte order
module qspi_io_shifter import qspi_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	inout  logic [3:0]  sio,
	input  qspi_cfg_t   cfg,
	input  mem_req_t    req,
	input  qspi_state_e state,
	input  logic [2:0]  beat,
	input  logic        drive_en,
	input  logic        capture,
	output logic [31:0] read_data
);

	logic [sync_stages-1:0][3:0] sync_q;
	logic [3:0] out_q;
	logic drive_q;
	logic [7:0] cmd_byte;
	logic [2:0] nib_idx;
	logic [7:0] wr_byte;
	logic [3:0] wr_nib;
	logic [31:0] adr_ext;
	logic [3:0] adr_nib;
	logic [3:0] out_nib;
	logic [31:0] rd_shift;

	assign sio = drive_q ? out_q : 4'bz;

	assign cmd_byte = req.is_write ? cfg.wr_cmd : cfg.rd_cmd;

	// beat counts down, wire order is byte 0 first with the high nibble leading
	assign nib_idx = nibble_last(req.size) - beat;
	assign wr_byte = req.wdata[{nib_idx[2:1], 3'b000} +: 8];
	assign wr_nib = nib_idx[0] ? wr_byte[3:0] : wr_byte[7:4];

	assign adr_ext = {8'h00, req.addr[23:0]};
	assign adr_nib = adr_ext[{beat, 2'b00} +: 4];

	always_comb begin
		case (state)
			// command goes out serially on SIO0
			st_cmd:   out_nib = {3'b000, cmd_byte[beat]};
			st_adr:   out_nib = adr_nib;
			st_wdata: out_nib = wr_nib;
			default:  out_nib = 4'h0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			drive_q <= 1'b0;
		else
			drive_q <= drive_en;
	end

	always_ff @(posedge clk) begin
		out_q <= out_nib;
		sync_q <= {sync_q[sync_stages-2:0], sio};
		if (capture)
			rd_shift <= {rd_shift[27:0], sync_q[sync_stages-1]};
	end

	// first received byte is the least significant one
	always_comb begin
		case (req.size)
			size_byte: read_data = {24'd0, rd_shift[7:0]};
			size_half: read_data = {16'd0, rd_shift[7:0], rd_shift[15:8]};
			default:   read_data = {rd_shift[7:0], rd_shift[15:8],
			                        rd_shift[23:16], rd_shift[31:24]};
		endcase
	end

endmodule

// File: qspi_ctrl.sv
`timescale 1ns/1ps
// quad-SPI memory controller top for up to three serial RAM or flash chips
// host issues one read or write at a time via mem_start and mem_req,
// configuration sits behind the APB port
module qspi_ctrl import qspi_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  apb_req_t          apb,
	output logic [31:0]       prdata,
	input  logic              mem_start,
	input  mem_req_t          mem_req,
	output logic              read_valid,
	output logic              write_finish,
	output logic [31:0]       read_data,
	output logic              sck,
	output logic [num_ce-1:0] ce_n,
	inout  logic [3:0]        sio
);

	qspi_cfg_t cfg;
	sck_evt_t evt;
	mem_req_t req;
	logic busy;
	qspi_state_e state;
	logic [2:0] beat;
	logic drive_en;
	logic capture;
	logic done;

	qspi_cfg_regs u_cfg_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.apb    (apb),
		.prdata (prdata),
		.cfg    (cfg)
	);

	qspi_sck_gen u_sck_gen (
		.clk   (clk),
		.rst_n (rst_n),
		.cfg   (cfg),
		.sck   (sck),
		.evt   (evt)
	);

	qspi_req_latch u_req_latch (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_start  (mem_start),
		.mem_req_in (mem_req),
		.done       (done),
		.req        (req),
		.busy       (busy)
	);

	qspi_sequencer u_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.evt          (evt),
		.req          (req),
		.busy         (busy),
		.state        (state),
		.beat         (beat),
		.drive_en     (drive_en),
		.capture      (capture),
		.ce_n         (ce_n),
		.done         (done),
		.read_valid   (read_valid),
		.write_finish (write_finish)
	);

	qspi_io_shifter u_io_shifter (
		.clk       (clk),
		.rst_n     (rst_n),
		.sio       (sio),
		.cfg       (cfg),
		.req       (req),
		.state     (state),
		.beat      (beat),
		.drive_en  (drive_en),
		.capture   (capture),
		.read_data (read_data)
	);

endmodule

// File: qspi_props.sv
`timescale 1ns/1ps
// concurrent checks on the quad-SPI controller, bound into qspi_ctrl
// covers chip select exclusivity, completion pulse shape and the SIO drive window
module qspi_props (
	input logic       clk,
	input logic       rst_n,
	input logic [2:0] ce_n,
	input logic       read_valid,
	input logic       write_finish,
	input logic       drive_en
);

	a_one_ce: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~ce_n) <= 1)
		else $error("more than one ce_n low");

	a_one_kind: assert property (@(posedge clk) disable iff (!rst_n)
		!(read_valid && write_finish))
		else $error("read_valid and write_finish high together");

	a_rv_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		read_valid |=> !read_valid)
		else $error("read_valid longer than one clock");

	a_wf_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		write_finish |=> !write_finish)
		else $error("write_finish longer than one clock");

	// the SIO output enable is drive_en one clock later
	a_drive_ce: assert property (@(posedge clk) disable iff (!rst_n)
		drive_en |=> (ce_n != 3'b111))
		else $error("SIO driven with no chip selected");

endmodule

bind qspi_ctrl qspi_props u_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.ce_n         (ce_n),
	.read_valid   (read_valid),
	.write_finish (write_finish),
	.drive_en     (drive_en)
);

// File: qspi_mem_model.sv
`timescale 1ns/1ps
// behavioral quad-SPI memory with three chips of 256 bytes each
// samples on the SCK rise, drives read nibbles after the SCK fall;
// raises err with a message on a wrong command byte or a wrong dummy count
module qspi_mem_model (
	input  logic            sck,
	input  logic [2:0]      ce_n,
	inout  wire  [3:0]      sio,
	input  logic [7:0]      rd_cmd,
	input  logic [7:0]      wr_cmd,
	input  logic [2:0][3:0] lat,
	output logic            err
);

	logic [7:0] mem [3][256];
	logic idle;
	logic is_rd;
	logic drive;
	logic [3:0] out_q;
	logic [3:0] hi_nib;
	logic [7:0] cmd;
	logic [23:0] adr;
	logic [7:0] rd_byte;
	int rises;
	int chip;
	int k;
	int n;

	assign idle = &ce_n;
	assign sio = drive ? out_q : 4'bz;

	initial begin
		err = 1'b0;
		drive = 1'b0;
		is_rd = 1'b0;
		rises = 0;
		chip = 0;
		for (int c = 0; c < 3; c++)
			for (int a = 0; a < 256; a++)
				mem[c][a] = 8'(a * 7 + c * 64 + 3);
	end

	always @(posedge sck or posedge idle) begin
		if (idle) begin
			// transfer just ended so check how many data nibbles went by
			if (rises != 0) begin
				n = is_rd ? rises - 14 - int'(lat[chip]) : rises - 14;
				if (!(n == 2 || n == 4 || n == 8)) begin
					if (is_rd)
						$display("memory model: wrong dummy cycle count on chip %0d", chip);
					else
						$display("memory model: wrong write nibble count on chip %0d", chip);
					err = 1'b1;
				end
			end
			rises = 0;
		end else begin
			if (rises < 8) begin
				if (rises == 0)
					chip = !ce_n[0] ? 0 : (!ce_n[1] ? 1 : 2);
				cmd = {cmd[6:0], sio[0]};
			end else if (rises < 14) begin
				if (rises == 8) begin
					if (cmd == rd_cmd) begin
						is_rd = 1'b1;
					end else if (cmd == wr_cmd) begin
						is_rd = 1'b0;
					end else begin
						$display("memory model: unexpected command byte %h on chip %0d",
							cmd, chip);
						err = 1'b1;
					end
				end
				adr = {adr[19:0], sio};
			end else if (!is_rd) begin
				// high nibble of each byte arrives first
				k = rises - 14;
				if (k[0] == 1'b0)
					hi_nib = sio;
				else
					mem[chip][adr[7:0] + 8'(k / 2)] = {hi_nib, sio};
			end
			rises++;
		end
	end

	always @(negedge sck or posedge idle) begin
		if (idle) begin
			drive = 1'b0;
		end else if (is_rd && rises >= 14 + int'(lat[chip])) begin
			k = rises - 14 - int'(lat[chip]);
			rd_byte = mem[chip][adr[7:0] + 8'(k / 2)];
			out_q = k[0] ? rd_byte[3:0] : rd_byte[7:4];
			drive = 1'b1;
		end
	end

endmodule

// File: tb_qspi_ctrl.sv
`timescale 1ns/1ps
// testbench for the quad-SPI memory controller
// runs the operations of qspi_testdata.txt against the DUT and a
// three-chip memory model, then compares the completion pulse counts
module tb_qspi_ctrl import qspi_pkg::*; ();

	localparam int max_ops = 64;

	logic clk;
	logic rst_n;
	apb_req_t apb;
	logic [31:0] prdata;
	logic mem_start;
	mem_req_t mem_req;
	logic read_valid;
	logic write_finish;
	logic [31:0] read_data;
	logic sck;
	logic [2:0] ce_n;
	wire [3:0] sio;

	// what the memory model expects on the wire
	logic [7:0] exp_rd_cmd;
	logic [7:0] exp_wr_cmd;
	logic [2:0][3:0] exp_lat;
	logic model_err;

	logic [3:0] op_code [max_ops];
	logic [31:0] op_addr [max_ops];
	logic [1:0] op_size [max_ops];
	logic [31:0] op_data [max_ops];
	int n_ops;
	int n_reads;
	int n_writes;
	int cycles;
	int cycle_limit;
	int rv_count;
	int wf_count;

	qspi_ctrl uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.apb          (apb),
		.prdata       (prdata),
		.mem_start    (mem_start),
		.mem_req      (mem_req),
		.read_valid   (read_valid),
		.write_finish (write_finish),
		.read_data    (read_data),
		.sck          (sck),
		.ce_n         (ce_n),
		.sio          (sio)
	);

	qspi_mem_model u_mem (
		.sck    (sck),
		.ce_n   (ce_n),
		.sio    (sio),
		.rd_cmd (exp_rd_cmd),
		.wr_cmd (exp_wr_cmd),
		.lat    (exp_lat),
		.err    (model_err)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	// completion pulse counters and the run time limit
	always @(negedge clk) begin
		cycles = cycles + 1;
		if (rst_n) begin
			rv_count = rv_count + int'(read_valid);
			wf_count = wf_count + int'(write_finish);
		end
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			stop_with_failure();
		end
	end

	always @(posedge model_err) begin
		stop_with_failure();
	end

	task automatic check_prdata(logic [7:0] addr, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t prdata at offset %h: got %h expected %h", $time, addr, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_read_data(logic [25:0] addr, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t read_data at %h: got %h expected %h", $time, addr, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			$display("[FAIL] %0t %s: got %0d expected %0d", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// field widths as the register map defines them
	task automatic update_model_cfg(logic [7:0] addr, logic [31:0] data);
		case (addr)
			8'h00: exp_lat[0] = data[3:0];
			8'h04: exp_lat[1] = data[3:0];
			8'h08: exp_lat[2] = data[3:0];
			8'h10: exp_rd_cmd = data[7:0];
			8'h14: exp_wr_cmd = data[7:0];
			default: ;
		endcase
	endtask

	task automatic apb_write(logic [7:0] addr, logic [31:0] data);
		@(negedge clk);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(negedge clk);
		apb.penable = 1'b1;
		@(negedge clk);
		apb = '0;
	endtask

	task automatic apb_read_check(logic [7:0] addr, logic [31:0] exp);
		@(negedge clk);
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		@(negedge clk);
		apb.penable = 1'b1;
		@(negedge clk);
		check_prdata(addr, prdata, exp);
		apb = '0;
	endtask

	task automatic mem_transfer(logic is_write, logic [25:0] addr, logic [1:0] size,
		logic [31:0] data);
		@(negedge clk);
		mem_req.is_write = is_write;
		mem_req.size = xfer_size_e'(size);
		mem_req.addr = addr;
		mem_req.wdata = is_write ? data : 32'd0;
		mem_start = 1'b1;
		@(negedge clk);
		mem_start = 1'b0;
		forever begin
			@(negedge clk);
			if (read_valid || write_finish)
				break;
		end
		if (read_valid !== !is_write || write_finish !== is_write) begin
			$display("transfer at %h ended with the wrong completion pulse", addr);
			stop_with_failure();
		end else if (!is_write) begin
			check_read_data(addr, read_data, data);
		end
	endtask

	// counts clocks in one full SCK high phase
	task automatic measure_sck_high(int exp);
		int high;
		high = 1;
		forever begin
			@(negedge clk);
			if (!sck)
				break;
		end
		forever begin
			@(negedge clk);
			if (sck)
				break;
		end
		forever begin
			@(negedge clk);
			if (!sck)
				break;
			high++;
		end
		check_count("sck high clocks", high, exp);
	endtask

	task automatic load_testdata();
		int fd;
		int n;
		int max_div;
		string line;
		logic [31:0] f_op;
		logic [31:0] f_addr;
		logic [31:0] f_size;
		logic [31:0] f_data;
		max_div = 3;
		fd = $fopen("qspi_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open qspi_testdata.txt");
			stop_with_failure();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h", f_op, f_addr, f_size, f_data);
			if (n != 4 || n_ops >= max_ops) begin
				$display("bad or surplus line in qspi_testdata.txt: %s", line);
				stop_with_failure();
			end
			op_code[n_ops] = f_op[3:0];
			op_addr[n_ops] = f_addr;
			op_size[n_ops] = f_size[1:0];
			op_data[n_ops] = f_data;
			if (f_op == 0 && f_addr[7:0] == 8'h0c && int'(f_data[9:0]) > max_div)
				max_div = int'(f_data[9:0]);
			if (f_op == 2)
				n_writes++;
			if (f_op == 3)
				n_reads++;
			n_ops++;
		end
		$fclose(fd);
		// up to 40 SCK periods per operation at the slowest divider
		cycle_limit = n_ops * 40 * 2 * (max_div + 1) + 2000;
	endtask

	initial begin
		rst_n = 1'b0;
		apb = '0;
		mem_start = 1'b0;
		mem_req = '0;
		exp_rd_cmd = 8'heb;
		exp_wr_cmd = 8'h38;
		exp_lat = {3{4'd7}};
		cycles = 0;
		cycle_limit = 0;
		rv_count = 0;
		wf_count = 0;
		n_ops = 0;
		n_reads = 0;
		n_writes = 0;
		load_testdata();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_ops; i++) begin
			case (op_code[i])
				4'd0: begin
					update_model_cfg(op_addr[i][7:0], op_data[i]);
					apb_write(op_addr[i][7:0], op_data[i]);
				end
				4'd1: apb_read_check(op_addr[i][7:0], op_data[i]);
				4'd2: mem_transfer(1'b1, op_addr[i][25:0], op_size[i], op_data[i]);
				4'd3: mem_transfer(1'b0, op_addr[i][25:0], op_size[i], op_data[i]);
				4'd4: measure_sck_high(int'(op_data[i]));
				default: begin
					$display("unknown operation code %0d in line %0d", op_code[i], i);
					stop_with_failure();
				end
			endcase
		end
		// let the last chip select close before counting
		forever begin
			@(negedge clk);
			if (&ce_n)
				break;
		end
		check_count("read_valid pulses", rv_count, n_reads);
		check_count("write_finish pulses", wf_count, n_writes);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: qspi_testdata.txt
# columns: op addr size data, all hex; op 0 apb write, 1 apb read and compare,
# 2 memory write, 3 memory read and compare, 4 sck high clocks; size 0 byte 1 half 2 word
1 00 0 00000007
1 04 0 00000007
1 08 0 00000007
1 0c 0 00000003
1 10 0 000000eb
1 14 0 00000038
1 18 0 00000000
1 40 0 00000000
0 00 0 ffffffff
1 00 0 0000000f
0 04 0 12345608
1 04 0 00000008
0 08 0 abcdef03
1 08 0 00000003
0 0c 0 fffffc03
1 0c 0 00000003
0 18 0 ffffffff
1 18 0 00000000
2 0000010 2 a1b2c3d4
3 0000010 2 a1b2c3d4
2 1000020 2 0badf00d
3 1000020 2 0badf00d
2 2000030 2 13579bdf
3 2000030 2 13579bdf
2 1000040 2 11223344
2 1000041 0 000000aa
2 1000042 1 0000bbcc
3 1000040 2 bbccaa44
3 1000041 0 000000aa
3 1000042 1 0000bbcc
3 1000040 0 00000044
0 10 0 ffffff6b
0 14 0 00000102
1 10 0 0000006b
1 14 0 00000002
2 2000050 2 deadbeef
3 2000050 2 deadbeef
4 00 0 00000004
2 0000060 2 0f1e2d3c
3 0000060 2 0f1e2d3c
0 0c 0 00000005
1 0c 0 00000005
4 00 0 00000006
2 1000070 2 87654321
3 1000070 2 87654321

// File: flist.f
qspi_pkg.sv
qspi_sck_gen.sv
qspi_cfg_regs.sv
qspi_req_latch.sv
qspi_sequencer.sv
qspi_io_shifter.sv
qspi_ctrl.sv
qspi_props.sv
qspi_mem_model.sv
tb_qspi_ctrl.sv

// File: Makefile
# Verilator build and run of the quad-SPI controller testbench

TOP = tb_qspi_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
